//--- hdl/prefetchAddrPkg.sv
// address side types; addresses are 32-bit byte addresses, the window includes both ends
package prefetchAddrPkg;

    localparam int unsigned addrWidth = 32; // byte address width

    // byte address
    typedef logic [addrWidth-1:0] addrT;

    // unsigned difference of two addresses, wraps modulo 2^32
    typedef logic [addrWidth-1:0] strideT;

    // prefetch window, base <= addr <= limit
    typedef struct packed {
        addrT base;
        addrT limit;
    } windowT;

endpackage

//--- hdl/prefetchCtrlPkg.sv
// controller side types; the in-flight count is 8 bits, so maxOutstanding must stay below 256
package prefetchCtrlPkg;

    // stride learning FSM
    typedef enum logic [1:0] {
        sIdle   = 2'b00, // nothing learned yet
        sArm    = 2'b01, // one address seen, waiting for a stride
        sActive = 2'b10  // stride known, running ahead
    } ctrlStateT;

    // prefetches in flight
    typedef logic [7:0] countT;

endpackage

//--- hdl/strideTracker.sv
// strides are plain unsigned differences; the ahead address may wrap past 2^32 and then fails the window check
module strideTracker (
    input  logic                    clk,
    input  logic                    resetN,
    input  logic                    en,
    input  logic                    accept,
    input  prefetchAddrPkg::addrT   reqAddr,
    input  logic                    issue,
    input  prefetchAddrPkg::addrT   issuedAddr,
    input  logic                    loadStride,
    input  prefetchAddrPkg::strideT newStride,
    input  prefetchAddrPkg::windowT window,
    output logic                    rangeHit,
    output logic                    strideHit,
    output logic                    aheadInRange,
    output prefetchAddrPkg::strideT currentStride,
    output prefetchAddrPkg::strideT storedStride,
    output prefetchAddrPkg::addrT   aheadAddr
);
    import prefetchAddrPkg::*;

    addrT lastAddr;   // last accepted in-window demand address
    addrT lastIssued; // last address taken by the master port

    always_ff @(posedge clk) begin
        if (!resetN) begin
            storedStride <= '0;
        end else if (en && loadStride) begin
            storedStride <= newStride;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            if (accept && rangeHit) begin
                lastAddr <= reqAddr; // out-of-window requests leave history alone
            end
            if (issue) begin
                lastIssued <= issuedAddr;
            end
        end
    end

    assign currentStride = reqAddr - lastAddr;
    assign strideHit     = (currentStride == storedStride);
    assign rangeHit      = (reqAddr >= window.base) && (reqAddr <= window.limit);
    assign aheadAddr     = lastIssued + storedStride;
    assign aheadInRange  = (aheadAddr >= window.base) && (aheadAddr <= window.limit);

endmodule

//--- hdl/outstandingCounter.sv
// counts issued prefetches not yet filled; maxOutstanding must be 1..255, stray fills at zero are ignored
module outstandingCounter #(
    parameter int unsigned maxOutstanding = 4
) (
    input  logic clk,
    input  logic resetN,
    input  logic en,
    input  logic issue,
    input  logic fillValid,
    output logic mayIssue
);
    import prefetchCtrlPkg::*;

    countT count;

    always_ff @(posedge clk) begin
        if (!resetN) begin
            count <= '0;
        end else if (en) begin
            if (issue && !fillValid) begin
                count <= count + countT'(1);
            end else if (fillValid && !issue && (count != '0)) begin
                count <= count - countT'(1); // never below zero
            end
        end
    end

    // issue and fill together cancel out
    assign mayIssue = (count < countT'(maxOutstanding));

endmodule

//--- hdl/prefetchQueue.sv
// in-order queue of issued addresses; queueDepth is a power of two of at least 2, a flush wins over push and pop
module prefetchQueue #(
    parameter int unsigned queueDepth = 8
) (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  en,
    input  logic                  push,
    input  prefetchAddrPkg::addrT pushAddr,
    input  logic                  accept,
    input  prefetchAddrPkg::addrT reqAddr,
    input  logic                  flushN,
    output logic                  hit,
    output logic                  almostFull
);
    import prefetchAddrPkg::*;

    localparam int unsigned ptrWidth = $clog2(queueDepth);

    addrT                entries [queueDepth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [ptrWidth:0]   count;
    logic                headMatch;
    logic                doPush;
    logic                doPop;

    assign headMatch  = (count != '0) && (reqAddr == entries[rdPtr]);
    assign doPop      = accept && headMatch;
    assign doPush     = push && (count != (ptrWidth + 1)'(queueDepth)); // full drops the push
    assign almostFull = (count >= (ptrWidth + 1)'(queueDepth - 1));

    always_ff @(posedge clk) begin
        if (en && flushN && doPush) begin
            entries[wrPtr] <= pushAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            hit   <= 1'b0;
        end else if (en) begin
            if (!flushN) begin
                wrPtr <= '0; // queue empties
                rdPtr <= '0;
                count <= '0;
                hit   <= 1'b0;
            end else begin
                hit <= doPop;
                if (doPush) begin
                    wrPtr <= wrPtr + 1'b1;
                end
                if (doPop) begin
                    rdPtr <= rdPtr + 1'b1; // head matched, drop it
                end
                count <= count + (ptrWidth + 1)'(doPush) - (ptrWidth + 1)'(doPop);
            end
        end
    end

endmodule

//--- hdl/prefetcherCtrl.sv
// one prefetch address in flight on the master port at a time; demand requests wait while it is pending
module prefetcherCtrl (
    input  logic                    clk,
    input  logic                    resetN,
    input  logic                    en,
    input  logic                    inAddrReqValid,
    input  prefetchAddrPkg::addrT   inAddrReq,
    output logic                    inAddrReqReady,
    input  logic                    rangeHit,
    input  logic                    strideHit,
    input  logic                    aheadInRange,
    input  logic                    mayIssue,
    input  logic                    almostFull,
    input  prefetchAddrPkg::strideT currentStride,
    input  prefetchAddrPkg::addrT   aheadAddr,
    output logic                    accept,
    output logic                    loadStride,
    output logic                    issue,
    output logic                    prefetchedAddrValid,
    output prefetchAddrPkg::addrT   prefetchedAddr,
    input  logic                    prefetchedAddrReady,
    output logic                    flushN
);
    import prefetchAddrPkg::*;
    import prefetchCtrlPkg::*;

    ctrlStateT state;
    ctrlStateT nxtState;
    addrT      nxtAddr;
    logic      nxtValid;
    logic      nxtFlushN;
    logic      strideNonZero;
    logic      trainReq;

    assign inAddrReqReady = !prefetchedAddrValid; // hold off demand under back-pressure
    assign accept         = inAddrReqValid && inAddrReqReady && en;
    assign issue          = prefetchedAddrValid && prefetchedAddrReady && en;
    assign strideNonZero  = (currentStride != '0);
    assign trainReq       = accept && rangeHit;

    always_comb begin
        nxtState   = state;
        nxtValid   = prefetchedAddrValid;
        nxtAddr    = prefetchedAddr;
        nxtFlushN  = 1'b1;
        loadStride = 1'b0;

        if (prefetchedAddrValid) begin
            if (prefetchedAddrReady) begin
                nxtValid = 1'b0; // taken this cycle
            end
        end else begin
            case (state)
                sIdle: begin
                    if (trainReq) begin
                        nxtState = sArm;
                        nxtValid = 1'b1;
                        nxtAddr  = inAddrReq;
                    end
                end
                sArm: begin
                    if (trainReq && strideNonZero) begin
                        nxtState   = sActive;
                        loadStride = 1'b1;
                        nxtValid   = 1'b1;
                        nxtAddr    = inAddrReq;
                    end
                end
                sActive: begin
                    if (trainReq && strideNonZero && !strideHit) begin
                        // stride broke, drop what was queued and relearn
                        nxtState  = sArm;
                        nxtFlushN = 1'b0;
                        nxtValid  = 1'b1;
                        nxtAddr   = inAddrReq;
                    end else if (mayIssue && !almostFull && aheadInRange) begin
                        nxtValid = 1'b1; // run ahead
                        nxtAddr  = aheadAddr;
                    end
                end
                default: nxtState = sIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetN) begin
            state               <= sIdle;
            prefetchedAddrValid <= 1'b0;
            flushN              <= 1'b1;
        end else if (en) begin
            state               <= nxtState;
            prefetchedAddrValid <= nxtValid;
            flushN              <= nxtFlushN;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            prefetchedAddr <= nxtAddr;
        end
    end

endmodule

//--- hdl/prefetcherTop.sv
// stride prefetcher for reads only; the window must be held steady while en is high
module prefetcherTop #(
    parameter int unsigned queueDepth     = 8,
    parameter int unsigned maxOutstanding = 4
) (
    input  logic                    clk,
    input  logic                    resetN,
    input  logic                    en,
    input  logic                    inAddrReqValid,
    input  prefetchAddrPkg::addrT   inAddrReq,
    output logic                    inAddrReqReady,
    output logic                    prefetchedAddrValid,
    output prefetchAddrPkg::addrT   prefetchedAddr,
    input  logic                    prefetchedAddrReady,
    input  logic                    fillValid,
    input  prefetchAddrPkg::windowT window,
    output logic                    demandHit,
    output logic                    flushN,
    output logic                    queueAlmostFull
);
    logic                    rangeHit;
    logic                    strideHit;
    logic                    aheadInRange;
    logic                    mayIssue;
    logic                    accept;
    logic                    loadStride;
    logic                    issue;
    prefetchAddrPkg::strideT currentStride;
    prefetchAddrPkg::addrT   aheadAddr;

    strideTracker i_tracker (
        .clk, .resetN, .en, .accept, .reqAddr(inAddrReq), .issue,
        .issuedAddr(prefetchedAddr), .loadStride, .newStride(currentStride), .window,
        .rangeHit, .strideHit, .aheadInRange, .currentStride, .storedStride(), .aheadAddr
    );

    outstandingCounter #(.maxOutstanding(maxOutstanding)) i_counter (
        .clk, .resetN, .en, .issue, .fillValid, .mayIssue
    );

    prefetchQueue #(.queueDepth(queueDepth)) i_queue (
        .clk, .resetN, .en, .push(issue), .pushAddr(prefetchedAddr), .accept,
        .reqAddr(inAddrReq), .flushN, .hit(demandHit), .almostFull(queueAlmostFull)
    );

    prefetcherCtrl i_ctrl (
        .clk, .resetN, .en, .inAddrReqValid, .inAddrReq, .inAddrReqReady, .rangeHit,
        .strideHit, .aheadInRange, .mayIssue, .almostFull(queueAlmostFull), .currentStride,
        .aheadAddr, .accept, .loadStride, .issue, .prefetchedAddrValid, .prefetchedAddr,
        .prefetchedAddrReady, .flushN
    );

endmodule

//--- testbench/prefetcher_properties.sv
// master port and flush rules of the controller; checks are off while resetN is low
module prefetcherProperties (
    input logic                  clk,
    input logic                  resetN,
    input prefetchAddrPkg::addrT inAddrReq,
    input logic                  prefetchedAddrValid,
    input prefetchAddrPkg::addrT prefetchedAddr,
    input logic                  prefetchedAddrReady,
    input logic                  flushN
);
    timeunit 1ns;
    timeprecision 100ps;

    // valid and address hold until the master port takes them
    validHold: assert property (@(posedge clk) disable iff (!resetN)
        prefetchedAddrValid && !prefetchedAddrReady |=> prefetchedAddrValid
            && $stable(prefetchedAddr))
        else $error("prefetch address dropped or changed before ready");

    flushPulse: assert property (@(posedge clk) disable iff (!resetN)
        !flushN |=> flushN) // one-cycle pulse only
        else $error("flushN low for two cycles");

    // the flush cycle carries the request that broke the stride
    flushAddr: assert property (@(posedge clk) disable iff (!resetN)
        $fell(flushN) |-> prefetchedAddrValid && prefetchedAddr == $past(inAddrReq))
        else $error("flush without the breaking address on the master port");

endmodule

//--- testbench/prefetcherTb.sv
// directed tests, 6-cycle memory model; each test starts from a fresh reset, window 0x1000..0x1FFF
module prefetcherTb;
    timeunit 1ns;
    timeprecision 100ps;
    import prefetchAddrPkg::*;
    import prefetchCtrlPkg::*;

    localparam int unsigned queueDepth = 8;
    localparam int unsigned maxOutstanding = 4;
    localparam int budgetCycles = 6 * 10 + 40 + 160 + 120 + 120 + 60 + 60; // resets plus tests

    logic clk = 1'b0;
    logic resetN, en, inAddrReqValid, inAddrReqReady, prefetchedAddrValid;
    logic prefetchedAddrReady, fillValid, demandHit, flushN, queueAlmostFull;
    addrT inAddrReq, prefetchedAddr;
    windowT window;
    addrT issuedQ [$]; // every address taken on the master port
    int errors = 0;
    int checks = 0;
    int flushLows = 0;
    int pendingFills = 0;
    int seed = 32'h9422_c9f7;
    int readyMode = 2; // 0 low, 1 high, 2 random
    logic fillsOn = 1'b1;
    logic [5:0] fillPipe = '0;

    prefetcherTop #(.queueDepth(queueDepth), .maxOutstanding(maxOutstanding)) i_dut (.*);
    bind prefetcherCtrl prefetcherProperties i_props (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin // ready source
        int randVal;
        randVal = $random(seed);
        #1;
        prefetchedAddrReady = (readyMode == 2) ? randVal[0] : (readyMode == 1);
    end

    always @(posedge clk) begin // memory model holds fills back while fillsOn is low
        if (!resetN) begin
            fillPipe = '0;
            pendingFills = 0;
        end else begin
            fillPipe = {fillPipe[4:0], prefetchedAddrValid && prefetchedAddrReady};
            if (fillPipe[5]) pendingFills++;
        end
        #1;
        fillValid = fillsOn && (pendingFills > 0);
        if (fillValid) pendingFills--;
    end

    always @(posedge clk) begin // issue and flush monitor
        if (resetN && en) begin
            if (prefetchedAddrValid && prefetchedAddrReady) issuedQ.push_back(prefetchedAddr);
            if (!flushN) flushLows++;
        end
    end

    initial begin // watchdog
        #(budgetCycles * 10 + 500);
        $display("watchdog expired, the tests did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

    task automatic checkAddr(input addrT got, input addrT exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkCount(input countT got, input countT exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic skipCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic resetDut(input int mode, input logic fills);
        resetN = 1'b0;
        inAddrReqValid = 1'b0;
        readyMode = mode;
        fillsOn = fills;
        repeat (8) @(posedge clk);
        #1;
        resetN = 1'b1;
        issuedQ.delete();
        flushLows = 0;
    endtask

    // holds the request until it is accepted, returns 1 ns after the accepting edge
    task automatic sendReq(input addrT addr);
        int waited;
        waited = 0;
        inAddrReqValid = 1'b1;
        inAddrReq = addr;
        while (!inAddrReqReady && waited < 100) begin // ready only moves on clock edges
            waited++;
            @(posedge clk);
            #1;
        end
        if (inAddrReqReady) begin
            @(posedge clk); // accepting edge
            #1;
        end else begin
            errors++;
            $display("demand request %h was never accepted", addr);
        end
        inAddrReqValid = 1'b0;
    endtask

    task automatic testOutOfWindow();
        resetDut(1, 1'b1);
        sendReq(32'h0800);
        sendReq(32'h3000);
        skipCycles(20);
        checkCount(countT'(issuedQ.size()), 0, "issues outside window");
    endtask

    task automatic testTraining();
        resetDut(2, 1'b0);
        sendReq(32'h1000);
        sendReq(32'h1040);
        skipCycles(60);
        checkCount(countT'(issuedQ.size()), countT'(maxOutstanding), "issues without fills");
        checkFlag(queueAlmostFull, 1'b0, "almost full with four queued");
        fillsOn = 1'b1;
        skipCycles(80); // fills let run-ahead continue until almost full
        checkCount(countT'(issuedQ.size()), countT'(queueDepth - 1), "issues after fills");
        checkFlag(queueAlmostFull, 1'b1, "almost full at one free entry");
        checkAddr(issuedQ[0], 32'h1000, "first issue");
        for (int i = 1; i < issuedQ.size(); i++) begin
            checkAddr(issuedQ[i], 32'h1000 + 32'h40 * i, "strided issue");
        end
    endtask

    task automatic testHits();
        resetDut(1, 1'b1);
        sendReq(32'h1000);
        sendReq(32'h1000); // zero stride in arm still pops the head
        checkFlag(demandHit, 1'b1, "hit on 1000");
        sendReq(32'h1040);
        skipCycles(30);
        sendReq(32'h1040);
        checkFlag(demandHit, 1'b1, "hit on 1040");
        sendReq(32'h1080);
        checkFlag(demandHit, 1'b1, "hit on 1080");
        sendReq(32'h10C0);
        checkFlag(demandHit, 1'b1, "hit on 10c0");
        sendReq(32'h10C0); // head has moved on
        checkFlag(demandHit, 1'b0, "hit on repeated 10c0");
    endtask

    task automatic testStrideChange();
        int idx;
        resetDut(1, 1'b1);
        sendReq(32'h1000);
        sendReq(32'h1040);
        skipCycles(20);
        sendReq(32'h1400);
        idx = issuedQ.size();
        checkFlag(flushN, 1'b0, "flushN after break");
        checkAddr(prefetchedAddr, 32'h1400, "address after break");
        skipCycles(1);
        checkFlag(flushN, 1'b1, "flushN one cycle later");
        sendReq(32'h1000);
        checkFlag(demandHit, 1'b0, "hit after flush");
        skipCycles(10);
        checkAddr(issuedQ[idx], 32'h1400, "issue after break");
        checkCount(countT'(flushLows), 1, "flush cycles");
    endtask

    task automatic testWindowEnd();
        resetDut(1, 1'b1);
        sendReq(32'h1800);
        sendReq(32'h1C00);
        skipCycles(30);
        checkCount(countT'(issuedQ.size()), 2, "issues near window end");
        foreach (issuedQ[i]) checkFlag(issuedQ[i] <= 32'h1FFF, 1'b1, "issue inside window");
    endtask

    task automatic testBackPressure();
        resetDut(0, 1'b1);
        sendReq(32'h1000);
        repeat (12) begin
            checkAddr(prefetchedAddr, 32'h1000, "held address");
            checkFlag(inAddrReqReady, 1'b0, "demand ready under back-pressure");
            skipCycles(1);
        end
        readyMode = 1;
        skipCycles(5);
        checkCount(countT'(issuedQ.size()), 1, "issues after ready");
        checkAddr(issuedQ[0], 32'h1000, "resumed issue");
    endtask

    initial begin
        resetN = 1'b0;
        en = 1'b1;
        inAddrReqValid = 1'b0;
        inAddrReq = '0;
        prefetchedAddrReady = 1'b0;
        fillValid = 1'b0;
        window = '{base: 32'h1000, limit: 32'h1FFF};
        testOutOfWindow();
        testTraining();
        testHits();
        testStrideChange();
        testWindowEnd();
        testBackPressure();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/prefetchAddrPkg.sv
hdl/prefetchCtrlPkg.sv
hdl/strideTracker.sv
hdl/outstandingCounter.sv
hdl/prefetchQueue.sv
hdl/prefetcherCtrl.sv
hdl/prefetcherTop.sv
testbench/prefetcher_properties.sv
testbench/prefetcherTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= prefetcherTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q ">>> PASS" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
